//--- hdl/usb_ctl_pkg.sv
`default_nettype none

package usb_ctl_pkg;

  // Field widths of the decoder and encoder interfaces
  localparam int ADDR_W = 7;
  localparam int ENDP_W = 4;
  localparam int BYTE_W = 8;

  // A SETUP data packet always carries eight bytes
  localparam int SETUP_BYTES = 8;

  // Token types as reported by the packet decoder
  localparam logic [1:0] TOK_OUT = 2'b00;
  localparam logic [1:0] TOK_SOF = 2'b01;
  localparam logic [1:0] TOK_IN = 2'b10;
  localparam logic [1:0] TOK_SETUP = 2'b11;

  // Handshake types
  localparam logic [1:0] HSK_ACK = 2'b00;
  localparam logic [1:0] HSK_NAK = 2'b10;

  // Data packet types
  localparam logic [1:0] PID_DATA0 = 2'b00;
  localparam logic [1:0] PID_DATA1 = 2'b10;

  // Control transfer stages
  // DATA_TOK is also the status-token wait
  typedef enum logic [3:0] {
    IDLE = 4'h0,
    SETUP_RX = 4'h1,
    SETUP_ACK = 4'h2,
    DATA_TOK = 4'h3,
    DATO_RX = 4'h4,
    DATO_ACK = 4'h5,
    DATI_TX = 4'h6,
    DATI_ACK = 4'h7,
    STATUS_RX = 4'h8,
    STATUS_TX = 4'h9,
    STATUS_ACK = 4'ha
  } ctl_stage_t;

  // Setup packet, written as bytes in arrival order and read as fields
  // Byte 0 sits in the low bits, so it lands in the request type
  typedef union packed {
    logic [SETUP_BYTES-1:0][BYTE_W-1:0] bytes;
    struct packed {
      logic [BYTE_W-1:0] length_hi;
      logic [BYTE_W-1:0] length_lo;
      logic [BYTE_W-1:0] index_hi;
      logic [BYTE_W-1:0] index_lo;
      logic [BYTE_W-1:0] value_hi;
      logic [BYTE_W-1:0] value_lo;
      logic [BYTE_W-1:0] request;
      logic [BYTE_W-1:0] rtype;
    } fields;
  } setup_pkt_u;

endpackage

`default_nettype wire

//--- hdl/setup_parser.sv
`timescale 1ns/1ps
`default_nettype none

module setup_parser (
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire                                 setup_clear_i,
  input  wire                                 setup_beat_i,
  input  wire                                 data_last_i,
  input  wire  [usb_ctl_pkg::BYTE_W-1:0]      usb_tdata_i,
  output logic                                setup_done_o,
  output logic                                dir_in_o,
  output logic                                ctl_start_o,
  output logic                                ctl_cycle_o,
  output logic [usb_ctl_pkg::BYTE_W-1:0]      ctl_rtype_o,
  output logic [usb_ctl_pkg::BYTE_W-1:0]      ctl_request_o,
  output logic [2*usb_ctl_pkg::BYTE_W-1:0]    ctl_value_o,
  output logic [2*usb_ctl_pkg::BYTE_W-1:0]    ctl_index_o,
  output logic [2*usb_ctl_pkg::BYTE_W-1:0]    ctl_length_o
);

  usb_ctl_pkg::setup_pkt_u pkt_q;

  // Byte pointer into the setup packet
  logic [$clog2(usb_ctl_pkg::SETUP_BYTES)-1:0] ptr_q;

  logic take_byte;

  // Bytes past the eighth are dropped
  assign take_byte = setup_beat_i && !setup_done_o;

  // Setup bytes, stored in arrival order
  always_ff @(posedge clock) begin
    if (reset) begin
      pkt_q <= '0;
    end else if (take_byte) begin
      pkt_q.bytes[ptr_q] <= usb_tdata_i;
    end
  end

  // Pointer, completion flag, start pulse and cycle flag
  always_ff @(posedge clock) begin
    if (reset || setup_clear_i) begin
      ptr_q <= '0;
      setup_done_o <= 1'b0;
      ctl_start_o <= 1'b0;
      ctl_cycle_o <= 1'b0;
    end else if (take_byte) begin
      ptr_q <= ptr_q + 1'b1;
      // Pointer all ones means this is the eighth byte
      if (&ptr_q) begin
        setup_done_o <= 1'b1;
        ctl_start_o <= 1'b1;
        ctl_cycle_o <= 1'b1;
      end
    end else begin
      ctl_start_o <= 1'b0;
      // Cycle ends with the last IN data beat
      if (data_last_i) begin
        ctl_cycle_o <= 1'b0;
      end
    end
  end

  // Request fields straight from the field view
  assign ctl_rtype_o = pkt_q.fields.rtype;
  assign ctl_request_o = pkt_q.fields.request;
  assign ctl_value_o = {pkt_q.fields.value_hi, pkt_q.fields.value_lo};
  assign ctl_index_o = {pkt_q.fields.index_hi, pkt_q.fields.index_lo};
  assign ctl_length_o = {pkt_q.fields.length_hi, pkt_q.fields.length_lo};

  // Device-to-host when bit 7 of the request type is set
  assign dir_in_o = pkt_q.fields.rtype[7];

endmodule

`default_nettype wire

//--- hdl/ctl_stage_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_stage_fsm (
  input  wire                              clock,
  input  wire                              reset,
  input  wire  [usb_ctl_pkg::ADDR_W-1:0]   usb_addr_i,
  input  wire                              tok_recv_i,
  input  wire  [1:0]                       tok_type_i,
  input  wire  [usb_ctl_pkg::ADDR_W-1:0]   tok_addr_i,
  input  wire  [usb_ctl_pkg::ENDP_W-1:0]   tok_endp_i,
  input  wire                              hsk_recv_i,
  input  wire  [1:0]                       hsk_type_i,
  input  wire                              hsk_sent_i,
  input  wire                              usb_recv_i,
  input  wire  [1:0]                       usb_type_i,
  input  wire                              usb_tvalid_i,
  input  wire                              usb_tlast_i,
  input  wire                              ctl_tvalid_i,
  input  wire                              ctl_tlast_i,
  input  wire                              usb_tready_i,
  input  wire                              setup_done_i,
  input  wire                              dir_in_i,
  input  wire                              length_zero_i,
  output logic                             setup_clear_o,
  output logic                             setup_beat_o,
  output logic                             data_last_o,
  output logic                             rx_ack_req_o,
  output logic                             tx_req_o,
  output logic [1:0]                       tx_pid_o,
  output logic                             ctl_tready_o,
  output logic                             ctl_done_o
);

  usb_ctl_pkg::ctl_stage_t state_q;

  logic       recv_q;
  logic [1:0] rx_pid_q;
  logic       toggle_q;
  logic       status_wait_q;
  logic       tx_issued_q;
  logic       tok_match;
  logic       tok_in;
  logic       tok_out;
  logic       host_ack;
  logic       rx_zero;
  logic       rx_end;
  logic       rx_stage;

  // Tokens for our address on endpoint 0
  assign tok_match = tok_recv_i && tok_addr_i == usb_addr_i && tok_endp_i == '0;
  assign tok_in = tok_match && tok_type_i == usb_ctl_pkg::TOK_IN;
  assign tok_out = tok_match && tok_type_i == usb_ctl_pkg::TOK_OUT;

  assign host_ack = hsk_recv_i && hsk_type_i == usb_ctl_pkg::HSK_ACK;

  // Zero-length packet: tlast without valid one cycle after the header
  assign rx_zero = recv_q && !usb_tvalid_i && usb_tlast_i &&
                   rx_pid_q == usb_ctl_pkg::PID_DATA1;
  assign rx_end = (usb_tvalid_i && usb_tlast_i) || rx_zero;

  // Stages that answer a received packet with ACK
  assign rx_stage = state_q inside {usb_ctl_pkg::SETUP_RX, usb_ctl_pkg::DATO_RX,
                                    usb_ctl_pkg::STATUS_RX};

  // IN stream flows only during the data stage
  assign ctl_tready_o = state_q == usb_ctl_pkg::DATI_TX && usb_tready_i;
  assign data_last_o = ctl_tvalid_i && ctl_tready_o && ctl_tlast_i;

  // Decoder stream is always accepted
  assign setup_beat_o = state_q == usb_ctl_pkg::SETUP_RX && usb_tvalid_i;
  assign setup_clear_o = state_q == usb_ctl_pkg::IDLE;
  assign ctl_done_o = state_q == usb_ctl_pkg::IDLE;

  // Header strobe delayed to line up with the empty tlast
  always_ff @(posedge clock) begin
    if (reset) begin
      recv_q <= 1'b0;
    end else begin
      recv_q <= usb_recv_i;
    end
  end

  // PID of the packet being received
  always_ff @(posedge clock) begin
    if (usb_recv_i) begin
      rx_pid_q <= usb_type_i;
    end
  end

  // Request pulses toward the response block
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_ack_req_o <= 1'b0;
      tx_req_o <= 1'b0;
    end else begin
      rx_ack_req_o <= rx_stage && rx_end;
      // One data send per IN packet, on its first valid beat
      tx_req_o <= (state_q == usb_ctl_pkg::DATI_TX && ctl_tvalid_i && !tx_issued_q) ||
                  state_q == usb_ctl_pkg::STATUS_TX;
    end
  end

  // PID that goes with tx_req
  always_ff @(posedge clock) begin
    if (state_q == usb_ctl_pkg::STATUS_TX) begin
      tx_pid_o <= usb_ctl_pkg::PID_DATA1;
    end else if (state_q == usb_ctl_pkg::DATI_TX) begin
      tx_pid_o <= toggle_q ? usb_ctl_pkg::PID_DATA1 : usb_ctl_pkg::PID_DATA0;
    end
  end

  // Stage sequencing
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_ctl_pkg::IDLE;
      toggle_q <= 1'b1;
      status_wait_q <= 1'b0;
      tx_issued_q <= 1'b0;
    end else begin
      case (state_q)
        usb_ctl_pkg::IDLE: begin
          status_wait_q <= 1'b0;
          // Anything but a matching SETUP is ignored
          if (tok_match && tok_type_i == usb_ctl_pkg::TOK_SETUP) begin
            state_q <= usb_ctl_pkg::SETUP_RX;
          end
        end
        usb_ctl_pkg::SETUP_RX: begin
          if (rx_end) begin
            state_q <= usb_ctl_pkg::SETUP_ACK;
          end
        end
        usb_ctl_pkg::SETUP_ACK: begin
          if (hsk_sent_i) begin
            // First data packet is DATA1
            toggle_q <= 1'b1;
            status_wait_q <= length_zero_i;
            // Short setup packet drops the transfer
            state_q <= setup_done_i ? usb_ctl_pkg::DATA_TOK : usb_ctl_pkg::IDLE;
          end
        end
        usb_ctl_pkg::DATA_TOK: begin
          tx_issued_q <= 1'b0;
          // Token in the request direction opens a data packet
          if (tok_in) begin
            state_q <= dir_in_i && !status_wait_q ? usb_ctl_pkg::DATI_TX :
                                                    usb_ctl_pkg::STATUS_TX;
          end else if (tok_out) begin
            state_q <= !dir_in_i && !status_wait_q ? usb_ctl_pkg::DATO_RX :
                                                     usb_ctl_pkg::STATUS_RX;
          end
        end
        usb_ctl_pkg::DATO_RX: begin
          if (rx_end) begin
            state_q <= usb_ctl_pkg::DATO_ACK;
          end
        end
        usb_ctl_pkg::DATO_ACK: begin
          // More OUT packets may follow
          if (hsk_sent_i) begin
            toggle_q <= !toggle_q;
            state_q <= usb_ctl_pkg::DATA_TOK;
          end
        end
        usb_ctl_pkg::DATI_TX: begin
          if (ctl_tvalid_i) begin
            tx_issued_q <= 1'b1;
          end
          if (data_last_o) begin
            state_q <= usb_ctl_pkg::DATI_ACK;
          end
        end
        usb_ctl_pkg::DATI_ACK: begin
          // Single IN packet, so an ACK leads to the status stage
          if (host_ack) begin
            toggle_q <= !toggle_q;
            status_wait_q <= 1'b1;
            state_q <= usb_ctl_pkg::DATA_TOK;
          end else if (hsk_recv_i || tok_recv_i) begin
            state_q <= usb_ctl_pkg::IDLE;
          end
        end
        usb_ctl_pkg::STATUS_RX: begin
          if (rx_end) begin
            state_q <= usb_ctl_pkg::STATUS_ACK;
          end
        end
        usb_ctl_pkg::STATUS_TX: begin
          // Zero-length DATA1 is requested on the way out
          state_q <= usb_ctl_pkg::STATUS_ACK;
        end
        usb_ctl_pkg::STATUS_ACK: begin
          // Host ACK for a sent status, our ACK for a received one
          if (host_ack || hsk_sent_i) begin
            state_q <= usb_ctl_pkg::IDLE;
          end
        end
        default: begin
          state_q <= usb_ctl_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/ctl_response.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_response (
  input  wire        clock,
  input  wire        reset,
  input  wire        rx_ack_req_i,
  input  wire        tx_req_i,
  input  wire  [1:0] tx_pid_i,
  input  wire        hsk_sent_i,
  input  wire        usb_busy_i,
  output logic       hsk_send_o,
  output logic       usb_send_o,
  output logic [1:0] usb_type_o
);

  // Handshake request
  // Encoder always sends ACK, so only the request itself is held
  always_ff @(posedge clock) begin
    if (reset) begin
      hsk_send_o <= 1'b0;
    end else if (rx_ack_req_i) begin
      hsk_send_o <= 1'b1;
    end else if (hsk_sent_i) begin
      // Dropped once the encoder reports it sent
      hsk_send_o <= 1'b0;
    end
  end

  // Data send request
  always_ff @(posedge clock) begin
    if (reset) begin
      usb_send_o <= 1'b0;
    end else if (tx_req_i) begin
      usb_send_o <= 1'b1;
    end else if (usb_busy_i) begin
      // Busy means the encoder has taken the request
      usb_send_o <= 1'b0;
    end
  end

  // PID captured with the request, stable while it is pending
  always_ff @(posedge clock) begin
    if (tx_req_i) begin
      usb_type_o <= tx_pid_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/control_transfer.sv
`timescale 1ns/1ps
`default_nettype none

module control_transfer (
  input  wire                                 clock,
  input  wire                                 reset,
  // Configured device address
  input  wire  [usb_ctl_pkg::ADDR_W-1:0]      usb_addr_i,
  // Transfer status and request fields
  output logic                                ctl_done_o,
  output logic                                ctl_start_o,
  output logic                                ctl_cycle_o,
  output logic [usb_ctl_pkg::BYTE_W-1:0]      ctl_rtype_o,
  output logic [usb_ctl_pkg::BYTE_W-1:0]      ctl_request_o,
  output logic [2*usb_ctl_pkg::BYTE_W-1:0]    ctl_value_o,
  output logic [2*usb_ctl_pkg::BYTE_W-1:0]    ctl_index_o,
  output logic [2*usb_ctl_pkg::BYTE_W-1:0]    ctl_length_o,
  // IN data from the application
  input  wire                                 ctl_tvalid_i,
  output logic                                ctl_tready_o,
  input  wire                                 ctl_tlast_i,
  input  wire  [usb_ctl_pkg::BYTE_W-1:0]      ctl_tdata_i,
  // Decoder side
  input  wire                                 tok_recv_i,
  input  wire  [1:0]                          tok_type_i,
  input  wire  [usb_ctl_pkg::ADDR_W-1:0]      tok_addr_i,
  input  wire  [usb_ctl_pkg::ENDP_W-1:0]      tok_endp_i,
  input  wire                                 hsk_recv_i,
  input  wire  [1:0]                          hsk_type_i,
  input  wire                                 usb_recv_i,
  input  wire  [1:0]                          usb_type_i,
  input  wire                                 usb_tvalid_i,
  input  wire                                 usb_tlast_i,
  input  wire  [usb_ctl_pkg::BYTE_W-1:0]      usb_tdata_i,
  // Encoder side
  output logic                                hsk_send_o,
  input  wire                                 hsk_sent_i,
  output logic                                usb_send_o,
  output logic [1:0]                          usb_type_o,
  input  wire                                 usb_busy_i,
  output logic                                usb_tvalid_o,
  input  wire                                 usb_tready_i,
  output logic                                usb_tlast_o,
  output logic [usb_ctl_pkg::BYTE_W-1:0]      usb_tdata_o
);

  logic       setup_clear;
  logic       setup_beat;
  logic       data_last;
  logic       setup_done;
  logic       dir_in;
  logic       length_zero;
  logic       rx_ack_req;
  logic       tx_req;
  logic [1:0] tx_pid;

  // IN data goes straight to the encoder
  // Ready back to the application is gated by the stage machine
  assign usb_tvalid_o = ctl_tvalid_i;
  assign usb_tlast_o = ctl_tlast_i;
  assign usb_tdata_o = ctl_tdata_i;

  // No data stage when wLength is zero
  assign length_zero = ctl_length_o == '0;

  setup_parser u_parser (
    .clock         (clock),
    .reset         (reset),
    .setup_clear_i (setup_clear),
    .setup_beat_i  (setup_beat),
    .data_last_i   (data_last),
    .usb_tdata_i   (usb_tdata_i),
    .setup_done_o  (setup_done),
    .dir_in_o      (dir_in),
    .ctl_start_o   (ctl_start_o),
    .ctl_cycle_o   (ctl_cycle_o),
    .ctl_rtype_o   (ctl_rtype_o),
    .ctl_request_o (ctl_request_o),
    .ctl_value_o   (ctl_value_o),
    .ctl_index_o   (ctl_index_o),
    .ctl_length_o  (ctl_length_o)
  );

  ctl_stage_fsm u_stage (
    .clock         (clock),
    .reset         (reset),
    .usb_addr_i    (usb_addr_i),
    .tok_recv_i    (tok_recv_i),
    .tok_type_i    (tok_type_i),
    .tok_addr_i    (tok_addr_i),
    .tok_endp_i    (tok_endp_i),
    .hsk_recv_i    (hsk_recv_i),
    .hsk_type_i    (hsk_type_i),
    .hsk_sent_i    (hsk_sent_i),
    .usb_recv_i    (usb_recv_i),
    .usb_type_i    (usb_type_i),
    .usb_tvalid_i  (usb_tvalid_i),
    .usb_tlast_i   (usb_tlast_i),
    .ctl_tvalid_i  (ctl_tvalid_i),
    .ctl_tlast_i   (ctl_tlast_i),
    .usb_tready_i  (usb_tready_i),
    .setup_done_i  (setup_done),
    .dir_in_i      (dir_in),
    .length_zero_i (length_zero),
    .setup_clear_o (setup_clear),
    .setup_beat_o  (setup_beat),
    .data_last_o   (data_last),
    .rx_ack_req_o  (rx_ack_req),
    .tx_req_o      (tx_req),
    .tx_pid_o      (tx_pid),
    .ctl_tready_o  (ctl_tready_o),
    .ctl_done_o    (ctl_done_o)
  );

  ctl_response u_resp (
    .clock        (clock),
    .reset        (reset),
    .rx_ack_req_i (rx_ack_req),
    .tx_req_i     (tx_req),
    .tx_pid_i     (tx_pid),
    .hsk_sent_i   (hsk_sent_i),
    .usb_busy_i   (usb_busy_i),
    .hsk_send_o   (hsk_send_o),
    .usb_send_o   (usb_send_o),
    .usb_type_o   (usb_type_o)
  );

endmodule

`default_nettype wire

//--- sim/control_transfer_chk.sv
`timescale 1ns/1ps
`default_nettype none

module control_transfer_chk (
  input wire       clock,
  input wire       reset,
  input wire       hsk_req_i,
  input wire       hsk_done_i,
  input wire       data_req_i,
  input wire       data_taken_i,
  input wire [1:0] data_pid_i,
  input wire       start_i
);

  // Handshake request stays up until the encoder reports it sent
  hsk_hold: assert property (@(posedge clock) disable iff (reset)
    hsk_req_i && !hsk_done_i |=> hsk_req_i)
    else $error("Handshake request dropped before the encoder sent it");

  // PID must not move while the send request is pending
  pid_stable: assert property (@(posedge clock) disable iff (reset)
    data_req_i && !data_taken_i |=> $stable(data_pid_i))
    else $error("Data PID changed while the send request was pending");

  // Start is a single-cycle pulse
  start_pulse: assert property (@(posedge clock) disable iff (reset)
    start_i |=> !start_i)
    else $error("Start pulse lasted more than one cycle");

endmodule

bind control_transfer control_transfer_chk u_chk (
  .clock        (clock),
  .reset        (reset),
  .hsk_req_i    (hsk_send_o),
  .hsk_done_i   (hsk_sent_i),
  .data_req_i   (usb_send_o),
  .data_taken_i (usb_busy_i),
  .data_pid_i   (usb_type_o),
  .start_i      (ctl_start_o)
);

`default_nettype wire

//--- sim/tb_control_transfer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control_transfer;

  localparam int TIMEOUT = 200;
  localparam logic [6:0] DEV_ADDR = 7'h2a;

  logic clock;
  logic reset;
  logic [6:0] usb_addr_i;
  logic ctl_done_o;
  logic ctl_start_o;
  logic ctl_cycle_o;
  logic [7:0] ctl_rtype_o;
  logic [7:0] ctl_request_o;
  logic [15:0] ctl_value_o;
  logic [15:0] ctl_index_o;
  logic [15:0] ctl_length_o;
  logic ctl_tvalid_i;
  logic ctl_tready_o;
  logic ctl_tlast_i;
  logic [7:0] ctl_tdata_i;
  logic tok_recv_i;
  logic [1:0] tok_type_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  logic hsk_recv_i;
  logic [1:0] hsk_type_i;
  logic usb_recv_i;
  logic [1:0] usb_type_i;
  logic usb_tvalid_i;
  logic usb_tlast_i;
  logic [7:0] usb_tdata_i;
  logic hsk_send_o;
  logic hsk_sent_i;
  logic usb_send_o;
  logic [1:0] usb_type_o;
  logic usb_busy_i;
  logic usb_tvalid_o;
  logic usb_tready_i;
  logic usb_tlast_o;
  logic [7:0] usb_tdata_o;

  // Bookkeeping shared by the host tasks and the comparing process
  int errors = 0;
  int timeouts = 0;
  int start_count = 0;
  int hsk_count = 0;
  int send_count = 0;
  int base;
  logic [7:0] setup_bytes [8];
  logic [7:0] pkt [$];
  logic [7:0] exp_byte_q [$];
  logic [1:0] exp_pid_q [$];
  logic [7:0] next_byte;
  logic [7:0] exp_rtype;
  logic [7:0] exp_request;
  logic [15:0] exp_value;
  logic [15:0] exp_index;
  logic [15:0] exp_length;
  logic exp_dir;

  control_transfer u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Setup fields are little-endian words with the request type first
  function automatic void ref_setup(input logic [7:0] b [8], output logic [7:0] rtype,
                                    output logic [7:0] request, output logic [15:0] value,
                                    output logic [15:0] index, output logic [15:0] length,
                                    output logic dir);
    rtype = b[0];
    request = b[1];
    value = {b[3], b[2]};
    index = {b[5], b[4]};
    length = {b[7], b[6]};
    dir = b[0][7];
  endfunction

  // Status packet is DATA1 and data packets toggle starting from DATA1
  function automatic logic [1:0] ref_send_pid(input bit status_stage, input int packet_index);
    if (status_stage || packet_index % 2 == 0) begin
      return usb_ctl_pkg::PID_DATA1;
    end
    return usb_ctl_pkg::PID_DATA0;
  endfunction

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic fill_random(input int n);
    pkt.delete();
    repeat (n) begin
      pkt.push_back(8'($urandom));
    end
  endtask

  task automatic send_token(input logic [1:0] kind, input logic [6:0] addr,
                            input logic [3:0] endp);
    @(negedge clock);
    tok_recv_i = 1'b1;
    tok_type_i = kind;
    tok_addr_i = addr;
    tok_endp_i = endp;
    @(negedge clock);
    tok_recv_i = 1'b0;
  endtask

  task automatic send_hsk(input logic [1:0] kind);
    @(negedge clock);
    hsk_recv_i = 1'b1;
    hsk_type_i = kind;
    @(negedge clock);
    hsk_recv_i = 1'b0;
  endtask

  // Header strobe then the beats
  // An empty packet is a bare tlast
  task automatic send_data(input logic [1:0] pid, input logic [7:0] data [$]);
    @(negedge clock);
    usb_recv_i = 1'b1;
    usb_type_i = pid;
    @(negedge clock);
    usb_recv_i = 1'b0;
    if (data.size() == 0) begin
      usb_tlast_i = 1'b1;
      @(negedge clock);
    end else begin
      foreach (data[k]) begin
        usb_tvalid_i = 1'b1;
        usb_tdata_i = data[k];
        usb_tlast_i = (k == data.size() - 1);
        @(negedge clock);
      end
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
  endtask

  // Application side of the IN stream holds each byte until taken
  task automatic send_in_data(input logic [7:0] data [$]);
    int k;
    int guard;
    k = 0;
    guard = 0;
    while (k < data.size() && guard < TIMEOUT) begin
      ctl_tvalid_i = 1'b1;
      ctl_tdata_i = data[k];
      ctl_tlast_i = (k == data.size() - 1);
      @(posedge clock);
      if (ctl_tready_o) begin
        k++;
      end
      guard++;
      @(negedge clock);
    end
    ctl_tvalid_i = 1'b0;
    ctl_tlast_i = 1'b0;
    if (k < data.size()) begin
      timeouts++;
      $display("Timeout: IN stream stalled after %0d of %0d bytes", k, data.size());
    end
  endtask

  task automatic wait_hsk(input int target);
    int guard;
    guard = 0;
    while (hsk_count < target && guard < TIMEOUT) begin
      @(negedge clock);
      guard++;
    end
    if (hsk_count < target) begin
      timeouts++;
      $display("Timeout: DUT sent no handshake number %0d", target);
    end
  endtask

  task automatic wait_send(input int target);
    int guard;
    guard = 0;
    while (send_count < target && guard < TIMEOUT) begin
      @(negedge clock);
      guard++;
    end
    if (send_count < target) begin
      timeouts++;
      $display("Timeout: DUT requested no data packet number %0d", target);
    end
  endtask

  task automatic wait_done();
    int guard;
    guard = 0;
    while (!ctl_done_o && guard < TIMEOUT) begin
      @(negedge clock);
      guard++;
    end
    if (!ctl_done_o) begin
      timeouts++;
      $display("Timeout: transfer never returned to idle");
    end
  endtask

  // SETUP token plus its eight-byte DATA0 packet and then the device ACK
  task automatic run_setup(input logic [7:0] rtype, input logic [7:0] request,
                           input logic [15:0] length);
    int hsk_base;
    setup_bytes[0] = rtype;
    setup_bytes[1] = request;
    for (int k = 2; k < 6; k++) begin
      setup_bytes[k] = 8'($urandom);
    end
    setup_bytes[6] = length[7:0];
    setup_bytes[7] = length[15:8];
    ref_setup(setup_bytes, exp_rtype, exp_request, exp_value, exp_index, exp_length, exp_dir);
    pkt.delete();
    foreach (setup_bytes[k]) begin
      pkt.push_back(setup_bytes[k]);
    end
    hsk_base = hsk_count;
    send_token(usb_ctl_pkg::TOK_SETUP, DEV_ADDR, 4'h0);
    send_data(usb_ctl_pkg::PID_DATA0, pkt);
    // Start is visible in the cycle after the eighth byte
    check_val("ctl_start_o", 16'(ctl_start_o), 16'd1);
    wait_hsk(hsk_base + 1);
  endtask

  task automatic no_data_transfer(input logic [7:0] request);
    run_setup(8'h00, request, 16'h0000);
    exp_pid_q.push_back(ref_send_pid(1'b1, 0));
    send_token(usb_ctl_pkg::TOK_IN, DEV_ADDR, 4'h0);
    wait_send(send_count + 1);
    send_hsk(usb_ctl_pkg::HSK_ACK);
    wait_done();
  endtask

  // Encoder model with random ready gaps on the transmit stream
  initial begin
    forever begin
      @(negedge clock);
      hsk_sent_i = hsk_send_o && !hsk_sent_i;
      usb_busy_i = usb_send_o && !usb_busy_i;
      usb_tready_i = ($urandom % 4) != 0;
    end
  end

  // Comparing process samples on the rising edge
  initial begin
    forever begin
      @(posedge clock);
      if (!reset) begin
        if (ctl_start_o) begin
          start_count++;
          // Cycle flag rises together with the start pulse
          check_val("ctl_cycle_o", 16'(ctl_cycle_o), 16'd1);
          check_val("ctl_rtype_o", 16'(ctl_rtype_o), 16'(exp_rtype));
          check_val("ctl_request_o", 16'(ctl_request_o), 16'(exp_request));
          check_val("ctl_value_o", ctl_value_o, exp_value);
          check_val("ctl_index_o", ctl_index_o, exp_index);
          check_val("ctl_length_o", ctl_length_o, exp_length);
        end
        if (hsk_send_o && hsk_sent_i) begin
          hsk_count++;
        end
        if (usb_send_o && usb_busy_i) begin
          send_count++;
          assert (exp_pid_q.size() > 0) else begin
            errors++;
            $display("Unexpected data send request at %0t", $time);
          end
          if (exp_pid_q.size() > 0) begin
            check_val("usb_type_o", 16'(usb_type_o), 16'(exp_pid_q.pop_front()));
          end
        end
        if (usb_tvalid_o && usb_tready_i) begin
          check_val("ctl_tready_o", 16'(ctl_tready_o), 16'd1);
          assert (exp_byte_q.size() > 0) else begin
            errors++;
            $display("IN byte forwarded with none expected at %0t", $time);
          end
          if (exp_byte_q.size() > 0) begin
            next_byte = exp_byte_q.pop_front();
            check_val("usb_tdata_o", 16'(usb_tdata_o), 16'(next_byte));
            check_val("usb_tlast_o", 16'(usb_tlast_o), 16'(exp_byte_q.size() == 0));
          end
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    usb_addr_i = DEV_ADDR;
    ctl_tvalid_i = 1'b0;
    ctl_tlast_i = 1'b0;
    ctl_tdata_i = '0;
    tok_recv_i = 1'b0;
    tok_type_i = '0;
    tok_addr_i = '0;
    tok_endp_i = '0;
    hsk_recv_i = 1'b0;
    hsk_type_i = '0;
    usb_recv_i = 1'b0;
    usb_type_i = '0;
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
    usb_tdata_i = '0;
    hsk_sent_i = 1'b0;
    usb_busy_i = 1'b0;
    usb_tready_i = 1'b0;
    void'($urandom(32'hcd11c67e));
    repeat (2) @(negedge clock);
    reset = 1'b0;

    // Idle values after reset
    check_val("ctl_done_o", 16'(ctl_done_o), 16'd1);
    check_val("hsk_send_o", 16'(hsk_send_o), 16'd0);
    check_val("usb_send_o", 16'(usb_send_o), 16'd0);
    check_val("ctl_start_o", 16'(ctl_start_o), 16'd0);
    check_val("ctl_cycle_o", 16'(ctl_cycle_o), 16'd0);
    check_val("ctl_rtype_o", 16'(ctl_rtype_o), 16'd0);
    check_val("ctl_request_o", 16'(ctl_request_o), 16'd0);
    check_val("ctl_value_o", ctl_value_o, 16'd0);
    check_val("ctl_index_o", ctl_index_o, 16'd0);
    check_val("ctl_length_o", ctl_length_o, 16'd0);

    // SETUP to a foreign address and then to endpoint 1
    fill_random(8);
    send_token(usb_ctl_pkg::TOK_SETUP, DEV_ADDR ^ 7'h01, 4'h0);
    send_data(usb_ctl_pkg::PID_DATA0, pkt);
    send_token(usb_ctl_pkg::TOK_SETUP, DEV_ADDR, 4'h1);
    send_data(usb_ctl_pkg::PID_DATA0, pkt);
    repeat (4) @(negedge clock);
    check_val("hsk_send_o count", 16'(hsk_count), 16'd0);
    check_val("ctl_done_o", 16'(ctl_done_o), 16'd1);

    // No-data request
    no_data_transfer(8'h09);
    check_val("ctl_start_o count", 16'(start_count), 16'd1);

    // Control read with one IN packet and a zero-length OUT status
    run_setup(8'h80, 8'h06, 16'd12);
    check_val("ctl_rtype_o[7]", 16'(ctl_rtype_o[7]), 16'(exp_dir));
    fill_random(12);
    exp_byte_q = pkt;
    exp_pid_q.push_back(ref_send_pid(1'b0, 0));
    base = send_count;
    send_token(usb_ctl_pkg::TOK_IN, DEV_ADDR, 4'h0);
    send_in_data(pkt);
    wait_send(base + 1);
    check_val("IN bytes left", 16'(exp_byte_q.size()), 16'd0);
    check_val("ctl_cycle_o", 16'(ctl_cycle_o), 16'd0);
    send_hsk(usb_ctl_pkg::HSK_ACK);
    base = hsk_count;
    pkt.delete();
    send_token(usb_ctl_pkg::TOK_OUT, DEV_ADDR, 4'h0);
    send_data(usb_ctl_pkg::PID_DATA1, pkt);
    wait_hsk(base + 1);
    wait_done();

    // Control write with three OUT packets
    run_setup(8'h21, 8'h09, 16'd21);
    base = hsk_count;
    for (int p = 0; p < 3; p++) begin
      fill_random(p == 2 ? 5 : 8);
      send_token(usb_ctl_pkg::TOK_OUT, DEV_ADDR, 4'h0);
      send_data(ref_send_pid(1'b0, p), pkt);
      wait_hsk(base + p + 1);
    end
    check_val("hsk_send_o count", 16'(hsk_count - base), 16'd3);
    exp_pid_q.push_back(ref_send_pid(1'b1, 0));
    base = send_count;
    send_token(usb_ctl_pkg::TOK_IN, DEV_ADDR, 4'h0);
    wait_send(base + 1);
    send_hsk(usb_ctl_pkg::HSK_ACK);
    wait_done();

    // Host NAKs the IN data packet and a fresh request follows
    run_setup(8'h80, 8'h00, 16'd2);
    fill_random(2);
    exp_byte_q = pkt;
    exp_pid_q.push_back(ref_send_pid(1'b0, 0));
    base = send_count;
    send_token(usb_ctl_pkg::TOK_IN, DEV_ADDR, 4'h0);
    send_in_data(pkt);
    wait_send(base + 1);
    send_hsk(usb_ctl_pkg::HSK_NAK);
    wait_done();
    check_val("ctl_done_o", 16'(ctl_done_o), 16'd1);
    no_data_transfer(8'h05);

    repeat (4) @(negedge clock);
    check_val("ctl_start_o count", 16'(start_count), 16'd5);
    check_val("pending sends", 16'(exp_pid_q.size()), 16'd0);
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hdl/usb_ctl_pkg.sv
hdl/setup_parser.sv
hdl/ctl_stage_fsm.sv
hdl/ctl_response.sv
hdl/control_transfer.sv
sim/control_transfer_chk.sv
sim/tb_control_transfer.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the verdict
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_control_transfer \
  -o tb_control_transfer || { echo "Build failed"; exit 1; }
./obj_dir/tb_control_transfer 2>&1 | tee sim.log || echo "Simulation stopped with an error" >> sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
